/* src/loopback_pkg.sv */
// shared sizes for the loopback core; FIFO_DEPTH and LEN_QUEUE_DEPTH must be powers of two
`default_nettype none

package loopback_pkg;

    // byte storage of the frame FIFO
    localparam int FIFO_DEPTH = 64;
    localparam int FIFO_ADDR_W = $clog2(FIFO_DEPTH);

    // committed frames waiting for transmission
    localparam int LEN_QUEUE_DEPTH = 8;
    localparam int LQ_ADDR_W = $clog2(LEN_QUEUE_DEPTH);

    // longer frames are dropped as oversize
    localparam int MAX_FRAME_LEN = 32;
    localparam int LEN_W = $clog2(MAX_FRAME_LEN + 1);

    // idle transmit cycles after each frame
    localparam int IFG_CYCLES = 12;
    localparam int IFG_W = $clog2(IFG_CYCLES + 1);

    // statistics counters wrap at this width
    localparam int STAT_W = 16;
    localparam int STAT_COUNT = 5;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_SEND,
        TX_GAP
    } tx_state_t;

    // selector values double as counter indices
    typedef enum logic [2:0] {
        STAT_RX_GOOD     = 3'd0,
        STAT_RX_BAD      = 3'd1,
        STAT_RX_OVERSIZE = 3'd2,
        STAT_RX_OVERFLOW = 3'd3,
        STAT_TX_FRAMES   = 3'd4
    } stat_sel_t;

endpackage

`default_nettype wire

/* src/frame_fifo.sv */
// frame FIFO, no receive back-pressure: bad, oversize and non-fitting frames are dropped whole
`timescale 1ns/1ps
`default_nettype none

module frame_fifo import loopback_pkg::*; (
    input  wire logic             clk,
    input  wire logic             arst_n,

    input  wire logic             rx_dv,
    input  wire logic             rx_er,
    input  wire logic [7:0]       rxd,

    input  wire logic             rd_en,
    input  wire logic             frame_pop,
    output logic      [7:0]       rd_data,
    output logic                  frame_avail,
    output logic      [LEN_W-1:0] head_len,

    output logic                  rx_good,
    output logic                  rx_bad,
    output logic                  rx_oversize,
    output logic                  rx_overflow
);

logic [7:0]       mem [FIFO_DEPTH];
logic [LEN_W-1:0] lq_mem [LEN_QUEUE_DEPTH];

// pointers carry one extra bit to tell full from empty
logic [FIFO_ADDR_W:0] wr_ptr;
logic [FIFO_ADDR_W:0] wr_ptr_commit;
logic [FIFO_ADDR_W:0] rd_ptr;
logic [FIFO_ADDR_W:0] fifo_used;
logic [LQ_ADDR_W:0]   lq_wr;
logic [LQ_ADDR_W:0]   lq_rd;
logic [LQ_ADDR_W:0]   lq_used;

logic             rx_dv_q;
logic             frm_err;
logic             frm_over;
logic             frm_fit;
logic [LEN_W-1:0] frm_len;

logic fifo_full;
logic lq_full;
logic at_max;
logic wr_ok;
logic eof;
logic frm_good;

assign fifo_used = wr_ptr - rd_ptr;
assign fifo_full = fifo_used[FIFO_ADDR_W];
assign lq_used = lq_wr - lq_rd;
assign lq_full = lq_used[LQ_ADDR_W];

assign at_max = (frm_len == LEN_W'(MAX_FRAME_LEN));
// stop storing once a frame is known to be dropped anyway
assign wr_ok = rx_dv && frm_fit && !fifo_full && !at_max;
assign eof = rx_dv_q && !rx_dv;
assign frm_good = !frm_err && !frm_over && frm_fit && !lq_full;

assign frame_avail = (lq_wr != lq_rd);
assign head_len = lq_mem[lq_rd[LQ_ADDR_W-1:0]];

always_ff @(posedge clk) begin
    if (wr_ok) begin
        mem[wr_ptr[FIFO_ADDR_W-1:0]] <= rxd;
    end
    if (eof && frm_good) begin
        lq_mem[lq_wr[LQ_ADDR_W-1:0]] <= frm_len;
    end
    if (rd_en) begin
        rd_data <= mem[rd_ptr[FIFO_ADDR_W-1:0]];
    end
end

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        rx_dv_q <= 1'b0;
        wr_ptr <= '0;
        wr_ptr_commit <= '0;
        rd_ptr <= '0;
        lq_wr <= '0;
        lq_rd <= '0;
        frm_err <= 1'b0;
        frm_over <= 1'b0;
        frm_fit <= 1'b1;
        frm_len <= '0;
        rx_good <= 1'b0;
        rx_bad <= 1'b0;
        rx_oversize <= 1'b0;
        rx_overflow <= 1'b0;
    end else begin
        rx_dv_q <= rx_dv;
        rx_good <= 1'b0;
        rx_bad <= 1'b0;
        rx_oversize <= 1'b0;
        rx_overflow <= 1'b0;

        if (wr_ok) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
        if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
        if (frame_pop) begin
            lq_rd <= lq_rd + 1'b1;
        end

        // per-frame flags while bytes arrive
        if (rx_dv) begin
            if (rx_er) begin
                frm_err <= 1'b1;
            end
            if (at_max) begin
                frm_over <= 1'b1;
            end else begin
                frm_len <= frm_len + 1'b1;
                if (fifo_full) begin
                    frm_fit <= 1'b0;
                end
            end
        end

        // fate of the frame, one outcome only
        if (eof) begin
            frm_err <= 1'b0;
            frm_over <= 1'b0;
            frm_fit <= 1'b1;
            frm_len <= '0;
            if (frm_good) begin
                wr_ptr_commit <= wr_ptr;
                lq_wr <= lq_wr + 1'b1;
                rx_good <= 1'b1;
            end else begin
                wr_ptr <= wr_ptr_commit;
                rx_bad <= frm_err;
                rx_oversize <= !frm_err && frm_over;
                rx_overflow <= !frm_err && !frm_over;
            end
        end
    end
end

// reader must stay inside committed frames
assert property (@(posedge clk) disable iff (!arst_n) rd_en |-> (rd_ptr != wr_ptr_commit));

assert property (@(posedge clk) disable iff (!arst_n)
    $onehot0({rx_good, rx_bad, rx_oversize, rx_overflow}));

endmodule

`default_nettype wire

/* src/tx_ctrl.sv */
// transmit FSM, starts a frame only from idle with tx_enable high and always finishes it
`timescale 1ns/1ps
`default_nettype none

module tx_ctrl import loopback_pkg::*; (
    input  wire logic             clk,
    input  wire logic             arst_n,

    input  wire logic             tx_enable,
    input  wire logic             frame_avail,
    input  wire logic [LEN_W-1:0] head_len,
    input  wire logic [7:0]       rd_data,
    input  wire logic             gap_busy,

    output logic                  rd_en,
    output logic                  frame_pop,
    output logic                  gap_start,

    output logic                  tx_en,
    output logic      [7:0]       txd,
    output logic                  tx_done
);

tx_state_t        state;
logic [LEN_W-1:0] len;
logic [LEN_W-1:0] rd_cnt;
logic             rd_valid_q;
logic             last_q;

// one read per cycle until the whole frame is fetched
assign rd_en = (state == TX_SEND) && (rd_cnt != len);
assign frame_pop = rd_en && (LEN_W'(rd_cnt + 1'b1) == len);
// gap starts with the last byte on the wire
assign gap_start = (state == TX_SEND) && tx_done;

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        state <= TX_IDLE;
        len <= '0;
        rd_cnt <= '0;
        rd_valid_q <= 1'b0;
        last_q <= 1'b0;
        tx_en <= 1'b0;
        tx_done <= 1'b0;
    end else begin
        case (state)
            TX_IDLE: begin
                if (tx_enable && frame_avail) begin
                    state <= TX_SEND;
                    len <= head_len;
                    rd_cnt <= '0;
                end
            end
            TX_SEND: begin
                if (rd_en) begin
                    rd_cnt <= rd_cnt + 1'b1;
                end
                if (tx_done) begin
                    state <= TX_GAP;
                end
            end
            TX_GAP: begin
                if (!gap_busy) begin
                    state <= TX_IDLE;
                end
            end
            default: state <= TX_IDLE;
        endcase

        // rd_data lands one cycle after rd_en
        rd_valid_q <= rd_en;
        last_q <= frame_pop;
        tx_en <= rd_valid_q;
        tx_done <= last_q;
    end
end

always_ff @(posedge clk) begin
    txd <= rd_data;
end

assert property (@(posedge clk) disable iff (!arst_n) (state == TX_GAP) |-> !tx_en);

assert property (@(posedge clk) disable iff (!arst_n) rd_cnt <= LEN_W'(MAX_FRAME_LEN));

endmodule

`default_nettype wire

/* src/ifg_timer.sv */
// inter-frame gap timer, gap_busy high for exactly IFG_CYCLES cycles after gap_start
`timescale 1ns/1ps
`default_nettype none

module ifg_timer import loopback_pkg::*; (
    input  wire logic clk,
    input  wire logic arst_n,
    input  wire logic gap_start,
    output logic      gap_busy
);

logic [IFG_W-1:0] cnt;

assign gap_busy = (cnt != '0);

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        cnt <= '0;
    end else if (gap_start) begin
        cnt <= IFG_W'(IFG_CYCLES);
    end else if (gap_busy) begin
        cnt <= cnt - 1'b1;
    end
end

// transmit side must wait out the previous gap
assert property (@(posedge clk) disable iff (!arst_n) gap_start |-> !gap_busy);

endmodule

`default_nettype wire

/* src/stat_counters.sv */
// wrapping event counters, clear beats a same-cycle event, read-out has one cycle of latency
`timescale 1ns/1ps
`default_nettype none

module stat_counters import loopback_pkg::*; (
    input  wire logic              clk,
    input  wire logic              arst_n,

    input  wire logic              rx_good,
    input  wire logic              rx_bad,
    input  wire logic              rx_oversize,
    input  wire logic              rx_overflow,
    input  wire logic              tx_done,

    input  wire logic              stat_clear,
    input  wire stat_sel_t         stat_sel,
    output logic      [STAT_W-1:0] stat_value
);

logic [STAT_W-1:0]     cnt [STAT_COUNT];
logic [STAT_COUNT-1:0] evt;

// event bits follow the selector encoding
assign evt[STAT_RX_GOOD] = rx_good;
assign evt[STAT_RX_BAD] = rx_bad;
assign evt[STAT_RX_OVERSIZE] = rx_oversize;
assign evt[STAT_RX_OVERFLOW] = rx_overflow;
assign evt[STAT_TX_FRAMES] = tx_done;

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        for (int i = 0; i < STAT_COUNT; i++) begin
            cnt[i] <= '0;
        end
    end else begin
        for (int i = 0; i < STAT_COUNT; i++) begin
            if (stat_clear) begin
                cnt[i] <= '0;
            end else if (evt[i]) begin
                cnt[i] <= cnt[i] + 1'b1;
            end
        end
    end
end

// unused selector codes read as zero
always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        stat_value <= '0;
    end else if (int'(stat_sel) < STAT_COUNT) begin
        stat_value <= cnt[stat_sel];
    end else begin
        stat_value <= '0;
    end
end

endmodule

`default_nettype wire

/* src/loopback_core.sv */
// single-clock GMII-style frame loopback, no preamble or FCS handling and no receive back-pressure
`timescale 1ns/1ps
`default_nettype none

module loopback_core import loopback_pkg::*; (
    input  wire logic              clk,
    input  wire logic              arst_n,

    // receive side
    input  wire logic              rx_dv,
    input  wire logic              rx_er,
    input  wire logic [7:0]        rxd,

    // transmit side
    input  wire logic              tx_enable,
    output wire logic              tx_en,
    output wire logic [7:0]        txd,

    // statistics read port
    input  wire stat_sel_t         stat_sel,
    input  wire logic              stat_clear,
    output wire logic [STAT_W-1:0] stat_value
);

logic             rd_en;
logic             frame_pop;
logic [7:0]       rd_data;
logic             frame_avail;
logic [LEN_W-1:0] head_len;
logic             rx_good;
logic             rx_bad;
logic             rx_oversize;
logic             rx_overflow;
logic             gap_start;
logic             gap_busy;
logic             tx_done;

frame_fifo u_fifo (
    .clk(clk),
    .arst_n(arst_n),
    .rx_dv(rx_dv),
    .rx_er(rx_er),
    .rxd(rxd),
    .rd_en(rd_en),
    .frame_pop(frame_pop),
    .rd_data(rd_data),
    .frame_avail(frame_avail),
    .head_len(head_len),
    .rx_good(rx_good),
    .rx_bad(rx_bad),
    .rx_oversize(rx_oversize),
    .rx_overflow(rx_overflow)
);

tx_ctrl u_tx (
    .clk(clk),
    .arst_n(arst_n),
    .tx_enable(tx_enable),
    .frame_avail(frame_avail),
    .head_len(head_len),
    .rd_data(rd_data),
    .gap_busy(gap_busy),
    .rd_en(rd_en),
    .frame_pop(frame_pop),
    .gap_start(gap_start),
    .tx_en(tx_en),
    .txd(txd),
    .tx_done(tx_done)
);

ifg_timer u_ifg (
    .clk(clk),
    .arst_n(arst_n),
    .gap_start(gap_start),
    .gap_busy(gap_busy)
);

stat_counters u_stat (
    .clk(clk),
    .arst_n(arst_n),
    .rx_good(rx_good),
    .rx_bad(rx_bad),
    .rx_oversize(rx_oversize),
    .rx_overflow(rx_overflow),
    .tx_done(tx_done),
    .stat_clear(stat_clear),
    .stat_sel(stat_sel),
    .stat_value(stat_value)
);

endmodule

`default_nettype wire

/* verification/loopback_checker.sv */
// frame and statistics checker; its model assumes stat_clear never lands next to a frame event
`timescale 1ns/1ps
`default_nettype none

module loopback_checker import loopback_pkg::*; (
    input  wire logic              clk,
    input  wire logic              arst_n,
    input  wire logic              rx_dv,
    input  wire logic              rx_er,
    input  wire logic [7:0]        rxd,
    input  wire logic              tx_en,
    input  wire logic [7:0]        txd,
    input  wire logic              stat_clear,
    input  wire stat_sel_t         stat_sel,
    input  wire logic              stat_chk,
    input  wire logic [STAT_W-1:0] stat_value
);

logic [7:0]        cur_bytes [$];
logic              cur_err;
logic              dv_q;
// frames the model expects on tx, bytes kept flat
logic [7:0]        exp_bytes [$];
int                exp_lens [$];
int                occ;
int                lq_cnt;
logic [STAT_W-1:0] exp_cnt [STAT_COUNT];

logic              tx_q;
logic              seen_frame;
int                tx_cnt;
int                low_cnt;
int                frame_no;

logic              rd_pend;
stat_sel_t         rd_sel;
logic [STAT_W-1:0] rd_exp;

int    err_count = 0;
int    test_errs = 0;
int    tests_pass = 0;
int    tests_fail = 0;
string test_name = "reset";

function automatic int pending_frames();
    return exp_lens.size();
endfunction

task automatic count_error();
    err_count++;
    test_errs++;
endtask

task automatic start_test(input string name);
    test_name = name;
    test_errs = 0;
endtask

task automatic finish_test();
    if (test_errs == 0) begin
        tests_pass++;
        $display("test %s: passed", test_name);
    end else begin
        tests_fail++;
        $display("test %s: failed with %0d errors", test_name, test_errs);
    end
endtask

task automatic check_drained();
    if (exp_lens.size() != 0) begin
        $display("test %s: %0d expected frames never came out on tx", test_name, exp_lens.size());
        count_error();
    end
endtask

task automatic report();
    $display("tests run %0d, passed %0d, failed %0d, errors %0d",
             tests_pass + tests_fail, tests_pass, tests_fail, err_count);
endtask

// drop rules in priority order: bad, oversize, overflow
task automatic judge_frame();
    int len;
    len = cur_bytes.size();
    if (cur_err) begin
        exp_cnt[STAT_RX_BAD]++;
    end else if (len > MAX_FRAME_LEN) begin
        exp_cnt[STAT_RX_OVERSIZE]++;
    end else if (occ + len > FIFO_DEPTH || lq_cnt >= LEN_QUEUE_DEPTH) begin
        exp_cnt[STAT_RX_OVERFLOW]++;
    end else begin
        foreach (cur_bytes[i]) begin
            exp_bytes.push_back(cur_bytes[i]);
        end
        exp_lens.push_back(len);
        occ += len;
        lq_cnt++;
        exp_cnt[STAT_RX_GOOD]++;
    end
    cur_bytes.delete();
    cur_err = 1'b0;
endtask

task automatic close_tx_frame();
    int len;
    if (exp_lens.size() == 0) begin
        $display("test %s: frame of %0d bytes on tx while none was expected", test_name, tx_cnt);
        count_error();
    end else begin
        len = exp_lens.pop_front();
        if (tx_cnt != len) begin
            $display("Mismatch %s frame %0d length: expected %0d, actual %0d",
                     test_name, frame_no, len, tx_cnt);
            count_error();
        end
        for (int i = 0; i < len; i++) begin
            void'(exp_bytes.pop_front());
        end
        occ -= len;
        lq_cnt--;
        exp_cnt[STAT_TX_FRAMES]++;
        frame_no++;
    end
    seen_frame = 1'b1;
    // this sample is already the first idle cycle
    low_cnt = 1;
endtask

always @(posedge clk) begin
    if (!arst_n) begin
        cur_bytes.delete();
        exp_bytes.delete();
        exp_lens.delete();
        cur_err = 1'b0;
        dv_q = 1'b0;
        occ = 0;
        lq_cnt = 0;
        tx_q = 1'b0;
        seen_frame = 1'b0;
        tx_cnt = 0;
        low_cnt = 0;
        frame_no = 0;
        rd_pend = 1'b0;
        for (int i = 0; i < STAT_COUNT; i++) begin
            exp_cnt[i] = '0;
        end
    end else begin
        // read-out selected on the previous edge
        if (rd_pend && stat_value !== rd_exp) begin
            $display("Mismatch %s stat %s: expected %0d, actual %0d",
                     test_name, rd_sel.name(), rd_exp, stat_value);
            count_error();
        end
        rd_pend = stat_chk;
        rd_sel = stat_sel;
        rd_exp = (int'(stat_sel) < STAT_COUNT) ? exp_cnt[stat_sel] : '0;

        if (stat_clear) begin
            for (int i = 0; i < STAT_COUNT; i++) begin
                exp_cnt[i] = '0;
            end
        end

        if (rx_dv) begin
            cur_bytes.push_back(rxd);
            if (rx_er) begin
                cur_err = 1'b1;
            end
        end else if (dv_q) begin
            judge_frame();
        end
        dv_q = rx_dv;

        if (tx_en) begin
            if (!tx_q) begin
                if (seen_frame && low_cnt < IFG_CYCLES) begin
                    $display("test %s: tx gap of %0d cycles is below the minimum of %0d",
                             test_name, low_cnt, IFG_CYCLES);
                    count_error();
                end
                tx_cnt = 0;
            end
            if (exp_lens.size() > 0 && tx_cnt < exp_lens[0] && txd !== exp_bytes[tx_cnt]) begin
                $display("Mismatch %s frame %0d byte %0d: expected 0x%02h, actual 0x%02h",
                         test_name, frame_no, tx_cnt, exp_bytes[tx_cnt], txd);
                count_error();
            end
            tx_cnt++;
        end else if (tx_q) begin
            close_tx_frame();
        end else begin
            low_cnt++;
        end
        tx_q = tx_en;
    end
end

endmodule

`default_nettype wire

/* verification/tb_loopback.sv */
// loopback testbench, fixed seed; stats are read only while no frame is in flight
`timescale 1ns/1ps
`default_nettype none

module tb_loopback import loopback_pkg::*; ();

localparam int N_GOOD = 20;
localparam int N_FAULT = 16;
localparam int N_OVF = 12;
localparam int N_CLR = 6;
localparam int RX_GAP_MIN = 20;
localparam int RX_GAP_MAX = 30;
localparam int FAULT_LEN_MAX = 40;
// worst case per frame, doubled
localparam int TIMEOUT_CYCLES = 2 * (N_GOOD + N_FAULT + N_OVF + N_CLR)
                                * (MAX_FRAME_LEN + IFG_CYCLES + RX_GAP_MAX);
localparam int DRAIN_LIMIT = LEN_QUEUE_DEPTH * (MAX_FRAME_LEN + IFG_CYCLES + 8);

logic              clk;
logic              arst_n;
logic              rx_dv;
logic              rx_er;
logic [7:0]        rxd;
logic              tx_enable;
logic              tx_en;
logic [7:0]        txd;
stat_sel_t         stat_sel;
logic              stat_clear;
logic              stat_chk;
logic [STAT_W-1:0] stat_value;

loopback_core u_dut (
    .clk(clk),
    .arst_n(arst_n),
    .rx_dv(rx_dv),
    .rx_er(rx_er),
    .rxd(rxd),
    .tx_enable(tx_enable),
    .tx_en(tx_en),
    .txd(txd),
    .stat_sel(stat_sel),
    .stat_clear(stat_clear),
    .stat_value(stat_value)
);

loopback_checker u_chk (
    .clk(clk),
    .arst_n(arst_n),
    .rx_dv(rx_dv),
    .rx_er(rx_er),
    .rxd(rxd),
    .tx_en(tx_en),
    .txd(txd),
    .stat_clear(stat_clear),
    .stat_sel(stat_sel),
    .stat_chk(stat_chk),
    .stat_value(stat_value)
);

initial clk = 1'b0;
always #4 clk = ~clk;

function automatic int rand_range(input int lo, input int hi);
    return lo + int'($urandom % (hi - lo + 1));
endfunction

// err_pos below zero sends a clean frame
task automatic send_frame(input int len, input int err_pos);
    int gap;
    gap = rand_range(RX_GAP_MIN, RX_GAP_MAX);
    for (int i = 0; i < len; i++) begin
        @(posedge clk);
        rx_dv <= 1'b1;
        rx_er <= (i == err_pos);
        rxd <= 8'($urandom);
    end
    @(posedge clk);
    rx_dv <= 1'b0;
    rx_er <= 1'b0;
    rxd <= 8'h00;
    repeat (gap - 1) @(posedge clk);
endtask

task automatic send_good_frames(input int count);
    repeat (count) begin
        send_frame(rand_range(1, MAX_FRAME_LEN), -1);
    end
endtask

task automatic wait_drain();
    int n;
    n = 0;
    while (u_chk.pending_frames() != 0 && n < DRAIN_LIMIT) begin
        @(negedge clk);
        n++;
    end
    // let the last gap run out
    repeat (IFG_CYCLES + 4) @(negedge clk);
    u_chk.check_drained();
endtask

task automatic read_stats();
    for (int s = 0; s < STAT_COUNT; s++) begin
        @(posedge clk);
        stat_chk <= 1'b1;
        stat_sel <= stat_sel_t'(s);
    end
    @(posedge clk);
    stat_chk <= 1'b0;
    repeat (2) @(posedge clk);
endtask

task automatic clear_stats();
    @(posedge clk);
    stat_clear <= 1'b1;
    @(posedge clk);
    stat_clear <= 1'b0;
endtask

initial begin
    int cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
        @(posedge clk);
        cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
end

initial begin
    int len;
    int kind;
    arst_n = 1'b0;
    rx_dv = 1'b0;
    rx_er = 1'b0;
    rxd = 8'h00;
    tx_enable = 1'b0;
    stat_sel = STAT_RX_GOOD;
    stat_clear = 1'b0;
    stat_chk = 1'b0;
    void'($urandom(32'hd16c_13d1));
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);
    tx_enable <= 1'b1;

    u_chk.start_test("random_good");
    read_stats();
    send_good_frames(N_GOOD);
    wait_drain();
    read_stats();
    u_chk.finish_test();

    // error only, oversize only, or both
    u_chk.start_test("bad_oversize");
    repeat (N_FAULT) begin
        kind = rand_range(0, 2);
        if (kind == 0) begin
            len = rand_range(1, MAX_FRAME_LEN);
            send_frame(len, rand_range(0, len - 1));
        end else if (kind == 1) begin
            send_frame(rand_range(MAX_FRAME_LEN + 1, FAULT_LEN_MAX), -1);
        end else begin
            len = rand_range(MAX_FRAME_LEN + 1, FAULT_LEN_MAX);
            send_frame(len, rand_range(0, len - 1));
        end
    end
    wait_drain();
    read_stats();
    u_chk.finish_test();

    // frames pile up with tx held, then leave back to back
    u_chk.start_test("overflow");
    @(posedge clk);
    tx_enable <= 1'b0;
    send_good_frames(N_OVF);
    @(posedge clk);
    tx_enable <= 1'b1;
    wait_drain();
    read_stats();
    u_chk.finish_test();

    u_chk.start_test("clear_readout");
    clear_stats();
    read_stats();
    send_good_frames(N_CLR);
    wait_drain();
    read_stats();
    u_chk.finish_test();

    u_chk.report();
    if (u_chk.err_count == 0) begin
        $display("TESTBENCH PASSED");
    end else begin
        $display("TESTBENCH FAILED");
    end
    $finish;
end

endmodule

`default_nettype wire

/* list.f */
src/loopback_pkg.sv
src/frame_fifo.sv
src/tx_ctrl.sv
src/ifg_timer.sv
src/stat_counters.sv
src/loopback_core.sv
verification/loopback_checker.sv
verification/tb_loopback.sv

/* Makefile */
# Verilator build and run of the loopback testbench
VERILATOR ?= verilator
TOP       ?= tb_loopback
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

PASS_MSG  := TESTBENCH PASSED
SOURCES   := $(shell grep -v '^+' $(FILELIST))
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
